// ==== src/exec_pkg.sv ====
package exec_pkg;

    localparam int xlen  = 32;  // immediate layouts below are RV32 only
    localparam int tag_w = 6;   // rob tag

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [xlen-1:0]  word_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_func_e;

    typedef enum logic [1:0] {
        mul_mul    = 2'd0,
        mul_mulh   = 2'd1,
        mul_mulhsu = 2'd2,
        mul_mulhu  = 2'd3
    } mul_func_e;

    typedef enum logic [1:0] {
        opa_rs1  = 2'd0,
        opa_npc  = 2'd1,
        opa_pc   = 2'd2,
        opa_zero = 2'd3
    } opa_sel_e;

    typedef enum logic [2:0] {
        opb_rs2   = 3'd0,
        opb_i_imm = 3'd1,
        opb_b_imm = 3'd2,
        opb_u_imm = 3'd3,
        opb_j_imm = 3'd4
    } opb_sel_e;

    // funct3 of the branch opcodes
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_cond_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_fields_t;

    // raw bit groups the immediate formats are built from
    typedef struct packed {
        logic       sign;    // bit 31
        logic [5:0] b30_25;
        logic [3:0] b24_21;
        logic       b20;
        logic [7:0] b19_12;
        logic [3:0] b11_8;
        logic       b7;
        logic [6:0] opcode;
    } inst_format_t;

    typedef union packed {
        inst_fields_t field;
        inst_format_t fmt;
    } inst_u;

    function automatic word_t imm_i(inst_u inst);
        return {{21{inst.fmt.sign}}, inst.fmt.b30_25, inst.fmt.b24_21, inst.fmt.b20};
    endfunction

    function automatic word_t imm_b(inst_u inst);
        return {{20{inst.fmt.sign}}, inst.fmt.b7, inst.fmt.b30_25, inst.fmt.b11_8, 1'b0};
    endfunction

    function automatic word_t imm_u(inst_u inst);
        return {inst.fmt.sign, inst.fmt.b30_25, inst.fmt.b24_21, inst.fmt.b20,
                inst.fmt.b19_12, 12'b0};
    endfunction

    function automatic word_t imm_j(inst_u inst);
        return {{12{inst.fmt.sign}}, inst.fmt.b19_12, inst.fmt.b20, inst.fmt.b30_25,
                inst.fmt.b24_21, 1'b0};
    endfunction

endpackage

// ==== src/exec_if.sv ====
`timescale 1ns/1ps

interface issue_if;
    logic                  valid;
    logic                  ready;     // from alu_unit
    logic                  to_mult;   // steers to the multiplier
    exec_pkg::tag_t        tag;
    exec_pkg::alu_func_e   alu_func;
    exec_pkg::mul_func_e   mul_func;
    exec_pkg::opa_sel_e    opa_sel;
    exec_pkg::opb_sel_e    opb_sel;
    logic                  cond_branch;
    logic                  uncond_branch;
    exec_pkg::inst_u       inst;
    exec_pkg::word_t       pc;
    exec_pkg::word_t       npc_pred;
    exec_pkg::word_t       rs1;
    exec_pkg::word_t       rs2;

    modport alu (
        input  valid, to_mult, tag, alu_func, opa_sel, opb_sel,
        input  cond_branch, uncond_branch, inst, pc, npc_pred, rs1, rs2,
        output ready
    );

    modport mult (
        input valid, to_mult, tag, mul_func, rs1, rs2
    );
endinterface

interface done_if;
    logic            valid;
    logic            grant;   // unit result taken this cycle
    exec_pkg::tag_t  tag;
    exec_pkg::word_t result;
    logic            redirect;
    exec_pkg::word_t redirect_pc;

    modport src  (output valid, tag, result, redirect, redirect_pc, input grant);
    modport sink (input valid, tag, result, redirect, redirect_pc, output grant);
endinterface

// ==== src/operand_mux.sv ====
`timescale 1ns/1ps

module operand_mux (
    input  exec_pkg::opa_sel_e opa_sel,
    input  exec_pkg::opb_sel_e opb_sel,
    input  exec_pkg::inst_u    inst,
    input  exec_pkg::word_t    pc,
    input  exec_pkg::word_t    npc_pred,
    input  exec_pkg::word_t    rs1,
    input  exec_pkg::word_t    rs2,
    output exec_pkg::word_t    opa,
    output exec_pkg::word_t    opb
);

    exec_pkg::word_t i_imm;
    exec_pkg::word_t b_imm;
    exec_pkg::word_t u_imm;
    exec_pkg::word_t j_imm;

    // sign-extended immediates from the format view
    assign i_imm = exec_pkg::imm_i(inst);
    assign b_imm = exec_pkg::imm_b(inst);
    assign u_imm = exec_pkg::imm_u(inst);
    assign j_imm = exec_pkg::imm_j(inst);

    always_comb begin
        case (opa_sel)
            exec_pkg::opa_rs1:  opa = rs1;
            exec_pkg::opa_npc:  opa = npc_pred;  // link value for jumps
            exec_pkg::opa_pc:   opa = pc;
            exec_pkg::opa_zero: opa = '0;
            default:            opa = '0;
        endcase
    end

    always_comb begin
        case (opb_sel)
            exec_pkg::opb_rs2:   opb = rs2;
            exec_pkg::opb_i_imm: opb = i_imm;
            exec_pkg::opb_b_imm: opb = b_imm;
            exec_pkg::opb_u_imm: opb = u_imm;
            exec_pkg::opb_j_imm: opb = j_imm;
            default:             opb = '0;  // encodings 5..7 unused
        endcase
    end

endmodule

// ==== src/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input logic  clock,
    input logic  reset,
    input logic  flush,
    issue_if.alu issue,
    done_if.src  done
);

    exec_pkg::word_t opa;
    exec_pkg::word_t opb;
    exec_pkg::word_t alu_out;
    exec_pkg::word_t pc_plus4;
    exec_pkg::word_t true_npc;
    logic            cond_ok;
    logic            taken;
    logic            is_branch;
    logic            accept;

    // result hold register
    logic            held_valid;
    exec_pkg::tag_t  held_tag;
    exec_pkg::word_t held_result;
    logic            held_redirect;
    exec_pkg::word_t held_redirect_pc;

    operand_mux u_operand_mux (
        .opa_sel  (issue.opa_sel),
        .opb_sel  (issue.opb_sel),
        .inst     (issue.inst),
        .pc       (issue.pc),
        .npc_pred (issue.npc_pred),
        .rs1      (issue.rs1),
        .rs2      (issue.rs2),
        .opa      (opa),
        .opb      (opb)
    );

    always_comb begin
        case (issue.alu_func)
            exec_pkg::alu_add:  alu_out = opa + opb;
            exec_pkg::alu_sub:  alu_out = opa - opb;
            exec_pkg::alu_and:  alu_out = opa & opb;
            exec_pkg::alu_or:   alu_out = opa | opb;
            exec_pkg::alu_xor:  alu_out = opa ^ opb;
            exec_pkg::alu_slt:  alu_out = {31'b0, $signed(opa) < $signed(opb)};
            exec_pkg::alu_sltu: alu_out = {31'b0, opa < opb};
            exec_pkg::alu_sll:  alu_out = opa << opb[4:0];
            exec_pkg::alu_srl:  alu_out = opa >> opb[4:0];
            exec_pkg::alu_sra:  alu_out = $signed(opa) >>> opb[4:0];
            default:            alu_out = '0;
        endcase
    end

    // branch condition from funct3 on the register operands
    always_comb begin
        case (exec_pkg::br_cond_e'(issue.inst.field.funct3))
            exec_pkg::br_beq:  cond_ok = issue.rs1 == issue.rs2;
            exec_pkg::br_bne:  cond_ok = issue.rs1 != issue.rs2;
            exec_pkg::br_blt:  cond_ok = $signed(issue.rs1) < $signed(issue.rs2);
            exec_pkg::br_bge:  cond_ok = $signed(issue.rs1) >= $signed(issue.rs2);
            exec_pkg::br_bltu: cond_ok = issue.rs1 < issue.rs2;
            exec_pkg::br_bgeu: cond_ok = issue.rs1 >= issue.rs2;
            default:           cond_ok = 1'b0;
        endcase
    end

    assign is_branch = issue.cond_branch || issue.uncond_branch;
    assign taken     = issue.uncond_branch || (issue.cond_branch && cond_ok);
    assign pc_plus4  = issue.pc + 32'd4;
    assign true_npc  = taken ? alu_out : pc_plus4;

    // a granted result frees the register in the same cycle
    assign issue.ready = !held_valid || done.grant || issue.to_mult;
    assign accept      = issue.valid && !issue.to_mult && issue.ready;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            held_valid <= 1'b0;
        end else if (accept) begin
            held_valid <= 1'b1;
        end else if (done.grant) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            held_tag         <= issue.tag;
            held_result      <= alu_out;
            held_redirect    <= is_branch && (true_npc != issue.npc_pred);
            held_redirect_pc <= true_npc;
        end
    end

    assign done.valid       = held_valid;
    assign done.tag         = held_tag;
    assign done.result      = held_result;
    assign done.redirect    = held_redirect;
    assign done.redirect_pc = held_redirect_pc;

endmodule

// ==== src/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit #(
    parameter int mult_stages = 4  // must divide 64
) (
    input logic   clock,
    input logic   reset,
    input logic   flush,
    issue_if.mult issue,
    done_if.src   done
);

    localparam int shift = 64 / mult_stages;  // multiplier bits per stage

    logic [63:0] ext_mcand;
    logic [63:0] ext_mplier;
    logic        start;
    logic        want_high;

    assign start = issue.valid && issue.to_mult;

    always_comb begin
        case (issue.mul_func)
            exec_pkg::mul_mulhsu: begin
                ext_mcand  = {{32{issue.rs1[31]}}, issue.rs1};
                ext_mplier = {32'b0, issue.rs2};
            end
            exec_pkg::mul_mulhu: begin
                ext_mcand  = {32'b0, issue.rs1};
                ext_mplier = {32'b0, issue.rs2};
            end
            default: begin  // mul and mulh take both signed
                ext_mcand  = {{32{issue.rs1[31]}}, issue.rs1};
                ext_mplier = {{32{issue.rs2[31]}}, issue.rs2};
            end
        endcase
    end

    assign want_high = issue.mul_func != exec_pkg::mul_mul;

    for (genvar i = 0; i < mult_stages; i++) begin : g_stage
        logic [63:0]    prev_sum;
        logic [63:0]    prev_mplier;
        logic [63:0]    prev_mcand;
        logic           prev_valid;
        exec_pkg::tag_t prev_tag;
        logic           prev_high;
        logic [63:0]    partial;
        logic [63:0]    sum_q;
        logic [63:0]    mplier_q;
        logic [63:0]    mcand_q;
        logic           valid_q;
        exec_pkg::tag_t tag_q;
        logic           high_q;

        if (i == 0) begin : g_first
            assign prev_sum    = '0;
            assign prev_mplier = ext_mplier;
            assign prev_mcand  = ext_mcand;
            assign prev_valid  = start;
            assign prev_tag    = issue.tag;
            assign prev_high   = want_high;
        end else begin : g_next
            assign prev_sum    = g_stage[i-1].sum_q;
            assign prev_mplier = g_stage[i-1].mplier_q;
            assign prev_mcand  = g_stage[i-1].mcand_q;
            assign prev_valid  = g_stage[i-1].valid_q;
            assign prev_tag    = g_stage[i-1].tag_q;
            assign prev_high   = g_stage[i-1].high_q;
        end

        assign partial = 64'(prev_mplier[shift-1:0]) * prev_mcand;

        always_ff @(posedge clock) begin
            sum_q    <= prev_sum + partial;
            mplier_q <= prev_mplier >> shift;
            mcand_q  <= prev_mcand << shift;
            tag_q    <= prev_tag;
            high_q   <= prev_high;
        end

        always_ff @(posedge clock) begin
            if (reset || flush) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= prev_valid;
            end
        end
    end

    assign done.valid       = g_stage[mult_stages-1].valid_q;
    assign done.tag         = g_stage[mult_stages-1].tag_q;
    assign done.result      = g_stage[mult_stages-1].high_q ? g_stage[mult_stages-1].sum_q[63:32]
                                                            : g_stage[mult_stages-1].sum_q[31:0];
    assign done.redirect    = 1'b0;  // multiplies never redirect
    assign done.redirect_pc = '0;

endmodule

// ==== src/completion_arbiter.sv ====
`timescale 1ns/1ps

module completion_arbiter (
    input  logic            clock,
    input  logic            reset,
    input  logic            flush,
    done_if.sink            alu,
    done_if.sink            mult,
    output logic            valid,
    output exec_pkg::tag_t  tag,
    output exec_pkg::word_t result,
    output logic            redirect,
    output exec_pkg::word_t redirect_pc
);

    logic alu_wins;

    // multiplier cannot stall, so it always goes first
    assign alu_wins   = alu.valid && !mult.valid;
    assign alu.grant  = alu_wins;
    assign mult.grant = 1'b1;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid    <= 1'b0;
            redirect <= 1'b0;
        end else begin
            valid    <= mult.valid || alu.valid;
            redirect <= mult.valid ? mult.redirect : (alu_wins && alu.redirect);
        end
    end

    always_ff @(posedge clock) begin
        if (mult.valid) begin
            tag         <= mult.tag;
            result      <= mult.result;
            redirect_pc <= mult.redirect_pc;
        end else begin
            tag         <= alu.tag;
            result      <= alu.result;
            redirect_pc <= alu.redirect_pc;
        end
    end

endmodule

// ==== src/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster #(
    parameter int mult_stages = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                issue_valid,
    input  logic                issue_to_mult,
    input  exec_pkg::tag_t      issue_tag,
    input  exec_pkg::alu_func_e issue_alu_func,
    input  exec_pkg::mul_func_e issue_mul_func,
    input  exec_pkg::opa_sel_e  issue_opa_sel,
    input  exec_pkg::opb_sel_e  issue_opb_sel,
    input  logic                issue_cond_branch,
    input  logic                issue_uncond_branch,
    input  exec_pkg::word_t     issue_inst,
    input  exec_pkg::word_t     issue_pc,
    input  exec_pkg::word_t     issue_npc_pred,
    input  exec_pkg::word_t     issue_rs1,
    input  exec_pkg::word_t     issue_rs2,
    output logic                issue_ready,
    output logic                done_valid,
    output exec_pkg::tag_t      done_tag,
    output exec_pkg::word_t     done_result,
    output logic                done_redirect,
    output exec_pkg::word_t     done_redirect_pc
);

    issue_if issue_bus ();
    done_if  alu_done ();
    done_if  mult_done ();

    assign issue_bus.valid         = issue_valid;
    assign issue_bus.to_mult       = issue_to_mult;
    assign issue_bus.tag           = issue_tag;
    assign issue_bus.alu_func      = issue_alu_func;
    assign issue_bus.mul_func      = issue_mul_func;
    assign issue_bus.opa_sel       = issue_opa_sel;
    assign issue_bus.opb_sel       = issue_opb_sel;
    assign issue_bus.cond_branch   = issue_cond_branch;
    assign issue_bus.uncond_branch = issue_uncond_branch;
    assign issue_bus.inst          = issue_inst;  // raw word into the union
    assign issue_bus.pc            = issue_pc;
    assign issue_bus.npc_pred      = issue_npc_pred;
    assign issue_bus.rs1           = issue_rs1;
    assign issue_bus.rs2           = issue_rs2;
    assign issue_ready             = issue_bus.ready;

    alu_unit u_alu (
        .clock (clock),
        .reset (reset),
        .flush (flush),
        .issue (issue_bus.alu),
        .done  (alu_done.src)
    );

    mult_unit #(
        .mult_stages (mult_stages)
    ) u_mult (
        .clock (clock),
        .reset (reset),
        .flush (flush),
        .issue (issue_bus.mult),
        .done  (mult_done.src)
    );

    completion_arbiter u_arbiter (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .alu         (alu_done.sink),
        .mult        (mult_done.sink),
        .valid       (done_valid),
        .tag         (done_tag),
        .result      (done_result),
        .redirect    (done_redirect),
        .redirect_pc (done_redirect_pc)
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime period = 8.0
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(period / 2.0) clock = ~clock;
    end

endmodule

// ==== test/exec_cluster_sva.sv ====
`timescale 1ns/1ps

module exec_cluster_sva (
    input logic clock,
    input logic reset,
    input logic flush,
    input logic issue_ready,
    input logic done_valid,
    input logic done_redirect
);

    // a redirect only ever rides on a valid completion
    a_redirect_valid: assert property (@(posedge clock) disable iff (reset)
        done_redirect |-> done_valid)
        else $error("done_redirect without done_valid");

    a_flush_clears: assert property (@(posedge clock) disable iff (reset)
        flush |=> !done_valid)
        else $error("done_valid one cycle after flush");

    a_ready_after_reset: assert property (@(posedge clock)
        reset |=> issue_ready)
        else $error("issue_ready low after reset");

endmodule

bind exec_cluster exec_cluster_sva u_sva (
    .clock         (clock),
    .reset         (reset),
    .flush         (flush),
    .issue_ready   (issue_ready),
    .done_valid    (done_valid),
    .done_redirect (done_redirect)
);

// ==== test/exec_cluster_tb.sv ====
`timescale 1ns/1ps

module exec_cluster_tb;

    localparam int mult_stages = 4;
    localparam int max_rec     = 40;
    localparam int rec_words   = 8;

    logic                clock;
    logic                reset;
    logic                flush;
    logic                issue_valid;
    logic                issue_to_mult;
    exec_pkg::tag_t      issue_tag;
    exec_pkg::alu_func_e issue_alu_func;
    exec_pkg::mul_func_e issue_mul_func;
    exec_pkg::opa_sel_e  issue_opa_sel;
    exec_pkg::opb_sel_e  issue_opb_sel;
    logic                issue_cond_branch;
    logic                issue_uncond_branch;
    exec_pkg::word_t     issue_inst;
    exec_pkg::word_t     issue_pc;
    exec_pkg::word_t     issue_npc_pred;
    exec_pkg::word_t     issue_rs1;
    exec_pkg::word_t     issue_rs2;
    logic                issue_ready;
    logic                done_valid;
    exec_pkg::tag_t      done_tag;
    exec_pkg::word_t     done_result;
    logic                done_redirect;
    exec_pkg::word_t     done_redirect_pc;

    logic [31:0]     pat_mem [0:max_rec*rec_words-1];
    exec_pkg::word_t exp_result [0:63];
    exec_pkg::word_t exp_rpc [0:63];
    logic [63:0]     exp_redirect;
    logic [63:0]     pending;
    logic [63:0]     cancelled;
    logic [63:0]     completed;
    int              num_rec;
    int              pend_count;
    int              cycle_count;
    int              cycle_limit;

    tb_clock #(.period(8.0)) u_clock (.clock(clock));

    exec_cluster #(.mult_stages(mult_stages)) UUT (.*);

    task automatic fail_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
            fail_run();
        end
    endtask

    // completions are scored before new issues and before flush
    always @(posedge clock) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("timeout after %0d cycles with %0d tags pending", cycle_count,
                         pend_count);
                fail_run();
            end
            if (done_valid) begin
                assert (pending[done_tag]) else begin
                    $display("completion for tag %h that is not pending at t=%0t",
                             done_tag, $time);
                    fail_run();
                end
                check_word("done_result", exp_result[done_tag], done_result);
                check_word("done_redirect", {31'b0, exp_redirect[done_tag]},
                           {31'b0, done_redirect});
                if (exp_redirect[done_tag]) begin
                    check_word("done_redirect_pc", exp_rpc[done_tag], done_redirect_pc);
                end
                pending[done_tag]   = 1'b0;
                completed[done_tag] = 1'b1;
                pend_count          = pend_count - 1;
            end
            if (issue_valid && issue_ready && !flush) begin
                pending[issue_tag] = 1'b1;
                pend_count         = pend_count + 1;
            end
            if (flush) begin
                cancelled  = cancelled | pending;
                pending    = '0;
                pend_count = 0;
            end
        end
    end

    task automatic drive_record(int r);
        logic [31:0] ctl;
        ctl                 = pat_mem[r*rec_words];
        flush               = ctl[31];
        issue_valid         = !ctl[31];
        issue_to_mult       = ctl[30];
        issue_cond_branch   = ctl[29];
        issue_uncond_branch = ctl[28];
        issue_opb_sel       = exec_pkg::opb_sel_e'(ctl[26:24]);
        issue_opa_sel       = exec_pkg::opa_sel_e'(ctl[21:20]);
        issue_mul_func      = exec_pkg::mul_func_e'(ctl[17:16]);
        issue_alu_func      = exec_pkg::alu_func_e'(ctl[15:12]);
        issue_tag           = ctl[5:0];
        issue_inst          = pat_mem[r*rec_words+1];
        issue_pc            = pat_mem[r*rec_words+2];
        issue_npc_pred      = pat_mem[r*rec_words+3];
        issue_rs1           = pat_mem[r*rec_words+4];
        issue_rs2           = pat_mem[r*rec_words+5];
    endtask

    initial begin
        int missing;
        logic [31:0] ctl;
        logic prev_mult;
        void'($urandom(32'h98ca_d77f));
        reset = 1'b1;
        flush = 1'b0;
        issue_valid = 1'b0;
        issue_to_mult = 1'b0;
        issue_tag = '0;
        issue_alu_func = exec_pkg::alu_add;
        issue_mul_func = exec_pkg::mul_mul;
        issue_opa_sel = exec_pkg::opa_rs1;
        issue_opb_sel = exec_pkg::opb_rs2;
        issue_cond_branch = 1'b0;
        issue_uncond_branch = 1'b0;
        issue_inst = '0;
        issue_pc = '0;
        issue_npc_pred = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        pending = '0;
        cancelled = '0;
        completed = '0;
        exp_redirect = '0;
        pend_count = 0;
        cycle_count = 0;
        cycle_limit = 1000;
        prev_mult = 1'b0;

        $readmemh("test/exec_patterns.hex", pat_mem);
        num_rec = 0;
        while (num_rec < max_rec && pat_mem[num_rec*rec_words] != 32'hffff_ffff) begin
            ctl = pat_mem[num_rec*rec_words];
            if (!ctl[31]) begin
                exp_result[ctl[5:0]]   = pat_mem[num_rec*rec_words+6];
                exp_rpc[ctl[5:0]]      = pat_mem[num_rec*rec_words+7];
                exp_redirect[ctl[5:0]] = ctl[8];
            end
            num_rec++;
        end
        cycle_limit = num_rec * (mult_stages + 4) + 100;

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int r = 0; r < num_rec; r++) begin
            ctl = pat_mem[r*rec_words];
            // multiplies stay back to back and a flush catches work in flight
            if (!ctl[31] && !ctl[30] && !prev_mult) begin
                repeat ($urandom_range(2, 0)) @(negedge clock);
            end
            prev_mult = ctl[30];
            drive_record(r);
            if (flush) begin
                @(negedge clock);
                flush = 1'b0;
            end else begin
                @(posedge clock);
                while (!issue_ready) @(posedge clock);  // held until accepted
                @(negedge clock);
                issue_valid = 1'b0;
            end
        end

        while (pend_count != 0) @(posedge clock);
        repeat (2) @(posedge clock);

        missing = 0;
        for (int r = 0; r < num_rec; r++) begin
            ctl = pat_mem[r*rec_words];
            if (!ctl[31] && !cancelled[ctl[5:0]] && !completed[ctl[5:0]]) begin
                $display("tag %h never completed", ctl[5:0]);
                missing++;
            end
        end
        if (missing == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

// ==== test/exec_patterns.hex ====
// ctl inst pc npc_pred rs1 rs2 exp_result exp_redirect_pc
// ctl: [31]flush [30]to_mult [29]cond [28]uncond [26:24]opb [21:20]opa [17:16]mul [15:12]alu [8]redir [5:0]tag
00000001 00000000 00000000 00000000 00000005 00000007 0000000C 00000000
00001002 00000000 00000000 00000000 00000003 00000005 FFFFFFFE 00000000
01002003 FF000000 00000000 00000000 12345678 00000000 12345670 00000000
03203004 ABCDE000 00000123 00000000 00000000 00000000 ABCDE123 00000000
00104005 00000000 00000000 0000FFFF 00000000 00FF00FF 00FFFF00 00000000
00005006 00000000 00000000 00000000 FFFFFFFF 00000001 00000001 00000000
00006007 00000000 00000000 00000000 FFFFFFFF 00000001 00000000 00000000
01007008 00400000 00000000 00000000 0000000F 00000000 000000F0 00000000
00008009 00000000 00000000 00000000 80000000 00000024 08000000 00000000
0000900A 00000000 00000000 00000000 80000000 00000024 F8000000 00000000
0430000B 00301000 00000000 00000000 00000000 00000000 00001802 00000000
0220000C 80000080 00001000 00000000 00000000 00000000 00000800 00000000
22200010 00000400 00000100 00000108 00000005 00000005 00000108 00000108
22200111 00001400 00000100 00000108 00000005 00000005 00000108 00000104
22200112 00004400 00000100 00000104 FFFFFFFE 00000001 00000108 00000108
22200013 00005400 00000100 00000104 FFFFFFFE 00000001 00000108 00000104
22200114 00006400 00000100 00000108 FFFFFFFE 00000001 00000108 00000104
22200015 00007400 00000100 00000108 FFFFFFFE 00000001 00000108 00000108
14200116 00301000 00000100 00000104 00000000 00000000 00001902 00001902
40000020 00000000 00000000 00000000 80000000 FFFFFFFF 80000000 00000000
40010021 00000000 00000000 00000000 80000000 FFFFFFFF 00000000 00000000
40020022 00000000 00000000 00000000 80000000 FFFFFFFF 80000000 00000000
40030023 00000000 00000000 00000000 80000000 FFFFFFFF 7FFFFFFF 00000000
40010024 00000000 00000000 00000000 7FFFFFFF 7FFFFFFF 3FFFFFFF 00000000
00000025 00000000 00000000 00000000 00000001 00000001 00000002 00000000
40030026 00000000 00000000 00000000 FFFFFFFF FFFFFFFF FFFFFFFE 00000000
00001027 00000000 00000000 00000000 00000010 00000001 0000000F 00000000
40000028 00000000 00000000 00000000 00000003 FFFFFFFB FFFFFFF1 00000000
40000030 00000000 00000000 00000000 00000002 00000003 00000006 00000000
00000031 00000000 00000000 00000000 00000001 00000002 00000003 00000000
80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
40030032 00000000 00000000 00000000 00010000 00010000 00000001 00000000
00003033 00000000 00000000 00000000 000000F0 0000000F 000000FF 00000000
FFFFFFFF 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// ==== filelist.f ====
src/exec_pkg.sv
src/exec_if.sv
src/operand_mux.sv
src/alu_unit.sv
src/mult_unit.sv
src/completion_arbiter.sv
src/exec_cluster.sv
test/tb_clock.sv
test/exec_cluster_sva.sv
test/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execution cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module exec_cluster_tb \
    -f filelist.f \
    -o exec_cluster_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/exec_cluster_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
